/* include/rs_cfg.svh */
`ifndef RS_CFG_SVH
`define RS_CFG_SVH

// Reservation station sizing
`define RS_NUM_ENTRIES 4
`define RS_NUM_WB      2

// Micro-op field widths
`define RS_XLEN        32
`define RS_PREG_W      6
`define RS_ROBID_W     5
`define RS_OPC_W       4

`endif

/* hw/instr_pkg.sv */
`include "rs_cfg.svh"

package instr_pkg;

    // Micro-op opcode as seen by the execution units
    typedef logic [`RS_OPC_W-1:0] t_opcode;

    // Reorder buffer slot of the micro-op
    typedef logic [`RS_ROBID_W-1:0] t_robid;

    // Physical register tag from rename
    typedef logic [`RS_PREG_W-1:0] t_preg;

    // Integer register data
    typedef logic [`RS_XLEN-1:0] t_xdata;

endpackage

/* hw/rs_pkg.sv */
`include "rs_cfg.svh"

package rs_pkg;

    typedef logic [$clog2(`RS_NUM_ENTRIES)-1:0] t_ent_idx;

    typedef enum logic {
        IDLE,
        VALID
    } t_ent_state;

    // Source operand readiness
    typedef enum logic {
        WAIT,
        READY
    } t_trk_state;

    typedef enum logic [1:0] {
        DISP_IDLE,
        DISP_ACK,
        DISP_DROP
    } t_disp_state;

    typedef enum logic [1:0] {
        ISS_IDLE,
        ISS_REQ,
        ISS_DROP
    } t_iss_state;

endpackage

/* hw/rs_reg_trk.sv */
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_reg_trk (
    input  logic               clk,
    input  logic               reset,
    input  logic               alloc,
    input  logic               alloc_pend,
    input  instr_pkg::t_preg   alloc_preg,
    input  instr_pkg::t_xdata  alloc_val,
    input  logic               wb_valid [`RS_NUM_WB-1:0],
    input  instr_pkg::t_preg   wb_preg  [`RS_NUM_WB-1:0],
    input  instr_pkg::t_xdata  wb_data  [`RS_NUM_WB-1:0],
    output logic               ready,
    output instr_pkg::t_xdata  src_data
);

    rs_pkg::t_trk_state state;
    instr_pkg::t_preg   tag;
    instr_pkg::t_preg   cmp_preg;
    logic               wb_hit;
    instr_pkg::t_xdata  wb_hit_data;

    // During allocation the incoming tag is not stored yet, so snoop with it directly
    assign cmp_preg = alloc ? alloc_preg : tag;

    always_comb begin
        wb_hit      = 1'b0;
        wb_hit_data = '0;
        for (int i = 0; i < `RS_NUM_WB; i++) begin
            if (wb_valid[i] && (wb_preg[i] == cmp_preg)) begin
                wb_hit      = 1'b1;
                wb_hit_data = wb_data[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rs_pkg::READY;
        end else if (alloc) begin
            state <= (!alloc_pend || wb_hit) ? rs_pkg::READY : rs_pkg::WAIT;
        end else if ((state == rs_pkg::WAIT) && wb_hit) begin
            state <= rs_pkg::READY;
        end
    end

    // Tag and operand value
    always_ff @(posedge clk) begin
        if (alloc) begin
            tag      <= alloc_preg;
            src_data <= alloc_pend ? wb_hit_data : alloc_val;
        end else if ((state == rs_pkg::WAIT) && wb_hit) begin
            src_data <= wb_hit_data;
        end
    end

    assign ready = (state == rs_pkg::READY);

endmodule

/* hw/rs_entry.sv */
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_entry (
    input  logic               clk,
    input  logic               reset,
    input  logic               alloc,
    input  instr_pkg::t_opcode opcode,
    input  instr_pkg::t_robid  robid,
    input  instr_pkg::t_preg   pdst,
    input  instr_pkg::t_preg   psrc1,
    input  instr_pkg::t_preg   psrc2,
    input  logic               src1_pend,
    input  logic               src2_pend,
    input  instr_pkg::t_xdata  src1_val,
    input  instr_pkg::t_xdata  src2_val,
    input  logic               wb_valid [`RS_NUM_WB-1:0],
    input  instr_pkg::t_preg   wb_preg  [`RS_NUM_WB-1:0],
    input  instr_pkg::t_xdata  wb_data  [`RS_NUM_WB-1:0],
    input  logic               gnt,
    output logic               valid,
    output logic               req,
    output instr_pkg::t_opcode e_opcode,
    output instr_pkg::t_robid  e_robid,
    output instr_pkg::t_preg   e_pdst,
    output instr_pkg::t_xdata  e_src1_val,
    output instr_pkg::t_xdata  e_src2_val
);

    rs_pkg::t_ent_state state;
    logic               src1_ready;
    logic               src2_ready;

    // Occupancy, freed once the issue is granted
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rs_pkg::IDLE;
        end else begin
            case (state)
                rs_pkg::IDLE:  if (alloc) state <= rs_pkg::VALID;
                rs_pkg::VALID: if (gnt) state <= rs_pkg::IDLE;
                default:       state <= rs_pkg::IDLE;
            endcase
        end
    end

    assign valid = (state == rs_pkg::VALID);

    // Fields that do not change while the entry waits
    always_ff @(posedge clk) begin
        if (alloc) begin
            e_opcode <= opcode;
            e_robid  <= robid;
            e_pdst   <= pdst;
        end
    end

    rs_reg_trk trk_src1 (
        .clk        (clk),
        .reset      (reset),
        .alloc      (alloc),
        .alloc_pend (src1_pend),
        .alloc_preg (psrc1),
        .alloc_val  (src1_val),
        .wb_valid   (wb_valid),
        .wb_preg    (wb_preg),
        .wb_data    (wb_data),
        .ready      (src1_ready),
        .src_data   (e_src1_val)
    );

    rs_reg_trk trk_src2 (
        .clk        (clk),
        .reset      (reset),
        .alloc      (alloc),
        .alloc_pend (src2_pend),
        .alloc_preg (psrc2),
        .alloc_val  (src2_val),
        .wb_valid   (wb_valid),
        .wb_preg    (wb_preg),
        .wb_data    (wb_data),
        .ready      (src2_ready),
        .src_data   (e_src2_val)
    );

    assign req = valid && src1_ready && src2_ready;

endmodule

/* hw/rs_dispatch_in.sv */
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_dispatch_in (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        disp_req,
    input  instr_pkg::t_opcode          disp_opcode,
    input  instr_pkg::t_robid           disp_robid,
    input  instr_pkg::t_preg            disp_pdst,
    input  instr_pkg::t_preg            disp_psrc1,
    input  instr_pkg::t_preg            disp_psrc2,
    input  logic                        disp_src1_pend,
    input  logic                        disp_src2_pend,
    input  instr_pkg::t_xdata           disp_src1_val,
    input  instr_pkg::t_xdata           disp_src2_val,
    output logic                        disp_ack,
    input  logic [`RS_NUM_ENTRIES-1:0]  ent_valid,
    output logic [`RS_NUM_ENTRIES-1:0]  alloc,
    output instr_pkg::t_opcode          a_opcode,
    output instr_pkg::t_robid           a_robid,
    output instr_pkg::t_preg            a_pdst,
    output instr_pkg::t_preg            a_psrc1,
    output instr_pkg::t_preg            a_psrc2,
    output logic                        a_src1_pend,
    output logic                        a_src2_pend,
    output instr_pkg::t_xdata           a_src1_val,
    output instr_pkg::t_xdata           a_src2_val
);

    rs_pkg::t_disp_state state;
    rs_pkg::t_ent_idx    free_idx;
    logic                any_free;
    logic                take;

    // Lowest-numbered free entry
    always_comb begin
        any_free = 1'b0;
        free_idx = '0;
        for (int i = `RS_NUM_ENTRIES - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                any_free = 1'b1;
                free_idx = rs_pkg::t_ent_idx'(i);
            end
        end
    end

    assign take = (state == rs_pkg::DISP_IDLE) && disp_req && any_free;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rs_pkg::DISP_IDLE;
            alloc <= '0;
        end else begin
            alloc <= '0;
            case (state)
                rs_pkg::DISP_IDLE: begin
                    if (take) begin
                        alloc[free_idx] <= 1'b1;
                        state           <= rs_pkg::DISP_ACK;
                    end
                end
                rs_pkg::DISP_ACK:  if (!disp_req) state <= rs_pkg::DISP_DROP;
                // Turnaround so the next request sees the new entry as taken
                rs_pkg::DISP_DROP: state <= rs_pkg::DISP_IDLE;
                default:           state <= rs_pkg::DISP_IDLE;
            endcase
        end
    end

    assign disp_ack = (state == rs_pkg::DISP_ACK);

    always_ff @(posedge clk) begin
        if (take) begin
            a_opcode    <= disp_opcode;
            a_robid     <= disp_robid;
            a_pdst      <= disp_pdst;
            a_psrc1     <= disp_psrc1;
            a_psrc2     <= disp_psrc2;
            a_src1_pend <= disp_src1_pend;
            a_src2_pend <= disp_src2_pend;
            a_src1_val  <= disp_src1_val;
            a_src2_val  <= disp_src2_val;
        end
    end

endmodule

/* hw/rs_issue_select.sv */
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_issue_select (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`RS_NUM_ENTRIES-1:0]  ent_req,
    input  instr_pkg::t_opcode          ent_opcode   [`RS_NUM_ENTRIES-1:0],
    input  instr_pkg::t_robid           ent_robid    [`RS_NUM_ENTRIES-1:0],
    input  instr_pkg::t_preg            ent_pdst     [`RS_NUM_ENTRIES-1:0],
    input  instr_pkg::t_xdata           ent_src1_val [`RS_NUM_ENTRIES-1:0],
    input  instr_pkg::t_xdata           ent_src2_val [`RS_NUM_ENTRIES-1:0],
    output logic [`RS_NUM_ENTRIES-1:0]  gnt,
    output logic                        iss_req,
    output instr_pkg::t_opcode          iss_opcode,
    output instr_pkg::t_robid           iss_robid,
    output instr_pkg::t_preg            iss_pdst,
    output instr_pkg::t_xdata           iss_src1_val,
    output instr_pkg::t_xdata           iss_src2_val,
    input  logic                        iss_ack
);

    rs_pkg::t_iss_state state;
    rs_pkg::t_ent_idx   sel_idx;
    rs_pkg::t_ent_idx   pick;
    logic               any_req;
    logic               launch;

    // Fixed priority, entry 0 wins
    always_comb begin
        any_req = 1'b0;
        pick    = '0;
        for (int i = `RS_NUM_ENTRIES - 1; i >= 0; i--) begin
            if (ent_req[i]) begin
                any_req = 1'b1;
                pick    = rs_pkg::t_ent_idx'(i);
            end
        end
    end

    assign launch = (state == rs_pkg::ISS_IDLE) && any_req && !iss_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= rs_pkg::ISS_IDLE;
            sel_idx <= '0;
        end else begin
            case (state)
                rs_pkg::ISS_IDLE: begin
                    if (launch) begin
                        sel_idx <= pick;
                        state   <= rs_pkg::ISS_REQ;
                    end
                end
                rs_pkg::ISS_REQ:  if (iss_ack) state <= rs_pkg::ISS_DROP;
                rs_pkg::ISS_DROP: if (!iss_ack) state <= rs_pkg::ISS_IDLE;
                default:          state <= rs_pkg::ISS_IDLE;
            endcase
        end
    end

    // Packet is frozen for the whole request
    always_ff @(posedge clk) begin
        if (launch) begin
            iss_opcode   <= ent_opcode[pick];
            iss_robid    <= ent_robid[pick];
            iss_pdst     <= ent_pdst[pick];
            iss_src1_val <= ent_src1_val[pick];
            iss_src2_val <= ent_src2_val[pick];
        end
    end

    assign iss_req = (state == rs_pkg::ISS_REQ);

    // Release the entry on the first acknowledged cycle
    always_comb begin
        gnt = '0;
        if (iss_req && iss_ack) begin
            gnt[sel_idx] = 1'b1;
        end
    end

endmodule

/* hw/rs_top.sv */
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               disp_req,
    input  instr_pkg::t_opcode disp_opcode,
    input  instr_pkg::t_robid  disp_robid,
    input  instr_pkg::t_preg   disp_pdst,
    input  instr_pkg::t_preg   disp_psrc1,
    input  instr_pkg::t_preg   disp_psrc2,
    input  logic               disp_src1_pend,
    input  logic               disp_src2_pend,
    input  instr_pkg::t_xdata  disp_src1_val,
    input  instr_pkg::t_xdata  disp_src2_val,
    output logic               disp_ack,
    input  logic               wb_valid [`RS_NUM_WB-1:0],
    input  instr_pkg::t_preg   wb_preg  [`RS_NUM_WB-1:0],
    input  instr_pkg::t_xdata  wb_data  [`RS_NUM_WB-1:0],
    output logic               iss_req,
    output instr_pkg::t_opcode iss_opcode,
    output instr_pkg::t_robid  iss_robid,
    output instr_pkg::t_preg   iss_pdst,
    output instr_pkg::t_xdata  iss_src1_val,
    output instr_pkg::t_xdata  iss_src2_val,
    input  logic               iss_ack
);

    logic [`RS_NUM_ENTRIES-1:0] alloc;
    logic [`RS_NUM_ENTRIES-1:0] gnt;
    logic [`RS_NUM_ENTRIES-1:0] ent_valid;
    logic [`RS_NUM_ENTRIES-1:0] ent_req;
    instr_pkg::t_opcode         ent_opcode   [`RS_NUM_ENTRIES-1:0];
    instr_pkg::t_robid          ent_robid    [`RS_NUM_ENTRIES-1:0];
    instr_pkg::t_preg           ent_pdst     [`RS_NUM_ENTRIES-1:0];
    instr_pkg::t_xdata          ent_src1_val [`RS_NUM_ENTRIES-1:0];
    instr_pkg::t_xdata          ent_src2_val [`RS_NUM_ENTRIES-1:0];

    // Latched micro-op shared by all entries
    instr_pkg::t_opcode         a_opcode;
    instr_pkg::t_robid          a_robid;
    instr_pkg::t_preg           a_pdst;
    instr_pkg::t_preg           a_psrc1;
    instr_pkg::t_preg           a_psrc2;
    logic                       a_src1_pend;
    logic                       a_src2_pend;
    instr_pkg::t_xdata          a_src1_val;
    instr_pkg::t_xdata          a_src2_val;

    rs_dispatch_in dispatch_in (
        .clk            (clk),
        .reset          (reset),
        .disp_req       (disp_req),
        .disp_opcode    (disp_opcode),
        .disp_robid     (disp_robid),
        .disp_pdst      (disp_pdst),
        .disp_psrc1     (disp_psrc1),
        .disp_psrc2     (disp_psrc2),
        .disp_src1_pend (disp_src1_pend),
        .disp_src2_pend (disp_src2_pend),
        .disp_src1_val  (disp_src1_val),
        .disp_src2_val  (disp_src2_val),
        .disp_ack       (disp_ack),
        .ent_valid      (ent_valid),
        .alloc          (alloc),
        .a_opcode       (a_opcode),
        .a_robid        (a_robid),
        .a_pdst         (a_pdst),
        .a_psrc1        (a_psrc1),
        .a_psrc2        (a_psrc2),
        .a_src1_pend    (a_src1_pend),
        .a_src2_pend    (a_src2_pend),
        .a_src1_val     (a_src1_val),
        .a_src2_val     (a_src2_val)
    );

    for (genvar e = 0; e < `RS_NUM_ENTRIES; e++) begin : g_ent
        rs_entry entry (
            .clk        (clk),
            .reset      (reset),
            .alloc      (alloc[e]),
            .opcode     (a_opcode),
            .robid      (a_robid),
            .pdst       (a_pdst),
            .psrc1      (a_psrc1),
            .psrc2      (a_psrc2),
            .src1_pend  (a_src1_pend),
            .src2_pend  (a_src2_pend),
            .src1_val   (a_src1_val),
            .src2_val   (a_src2_val),
            .wb_valid   (wb_valid),
            .wb_preg    (wb_preg),
            .wb_data    (wb_data),
            .gnt        (gnt[e]),
            .valid      (ent_valid[e]),
            .req        (ent_req[e]),
            .e_opcode   (ent_opcode[e]),
            .e_robid    (ent_robid[e]),
            .e_pdst     (ent_pdst[e]),
            .e_src1_val (ent_src1_val[e]),
            .e_src2_val (ent_src2_val[e])
        );
    end

    rs_issue_select issue_select (
        .clk          (clk),
        .reset        (reset),
        .ent_req      (ent_req),
        .ent_opcode   (ent_opcode),
        .ent_robid    (ent_robid),
        .ent_pdst     (ent_pdst),
        .ent_src1_val (ent_src1_val),
        .ent_src2_val (ent_src2_val),
        .gnt          (gnt),
        .iss_req      (iss_req),
        .iss_opcode   (iss_opcode),
        .iss_robid    (iss_robid),
        .iss_pdst     (iss_pdst),
        .iss_src1_val (iss_src1_val),
        .iss_src2_val (iss_src2_val),
        .iss_ack      (iss_ack)
    );

endmodule

/* testbench/rs_checker.sv */
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_checker (
    input  logic               clk,
    input  logic               reset,
    input  logic               disp_req,
    input  logic               disp_ack,
    input  instr_pkg::t_opcode disp_opcode,
    input  instr_pkg::t_robid  disp_robid,
    input  instr_pkg::t_preg   disp_pdst,
    input  instr_pkg::t_preg   disp_psrc1,
    input  instr_pkg::t_preg   disp_psrc2,
    input  logic               disp_src1_pend,
    input  logic               disp_src2_pend,
    input  instr_pkg::t_xdata  disp_src1_val,
    input  instr_pkg::t_xdata  disp_src2_val,
    input  logic               wb_valid [`RS_NUM_WB-1:0],
    input  instr_pkg::t_preg   wb_preg  [`RS_NUM_WB-1:0],
    input  instr_pkg::t_xdata  wb_data  [`RS_NUM_WB-1:0],
    input  logic               iss_req,
    input  instr_pkg::t_opcode iss_opcode,
    input  instr_pkg::t_robid  iss_robid,
    input  instr_pkg::t_preg   iss_pdst,
    input  instr_pkg::t_xdata  iss_src1_val,
    input  instr_pkg::t_xdata  iss_src2_val,
    input  logic               iss_ack,
    output int                 err_count,
    output int                 issued_count
);

    localparam int NUM_ROB = 2 ** `RS_ROBID_W;

    // Expected packet per ROB id, filled at dispatch and completed by writebacks
    logic               live  [NUM_ROB];
    instr_pkg::t_opcode opc   [NUM_ROB];
    instr_pkg::t_preg   pdst  [NUM_ROB];
    instr_pkg::t_preg   psrc1 [NUM_ROB];
    instr_pkg::t_preg   psrc2 [NUM_ROB];
    logic               pend1 [NUM_ROB];
    logic               pend2 [NUM_ROB];
    instr_pkg::t_xdata  val1  [NUM_ROB];
    instr_pkg::t_xdata  val2  [NUM_ROB];

    logic reset_q = 1'b0;
    logic req_q   = 1'b0;
    logic ack_q   = 1'b0;
    logic [`RS_OPC_W+`RS_ROBID_W+`RS_PREG_W+2*`RS_XLEN-1:0] pkt_q;

    initial begin
        err_count    = 0;
        issued_count = 0;
        for (int r = 0; r < NUM_ROB; r++) begin
            live[r] = 1'b0;
        end
    end

    task report(input string msg);
        err_count = err_count + 1;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    always @(posedge clk) begin
        if (reset_q && (disp_ack !== 1'b0 || iss_req !== 1'b0)) begin
            report("disp_ack or iss_req not low during reset");
        end
        if (!reset) begin
            if (disp_req && disp_ack) begin
                live[disp_robid]  = 1'b1;
                opc[disp_robid]   = disp_opcode;
                pdst[disp_robid]  = disp_pdst;
                psrc1[disp_robid] = disp_psrc1;
                psrc2[disp_robid] = disp_psrc2;
                pend1[disp_robid] = disp_src1_pend;
                pend2[disp_robid] = disp_src2_pend;
                val1[disp_robid]  = disp_src1_val;
                val2[disp_robid]  = disp_src2_val;
            end
            // Wakeups, including one in the allocation cycle
            for (int p = 0; p < `RS_NUM_WB; p++) begin
                for (int r = 0; r < NUM_ROB; r++) begin
                    if (wb_valid[p] && live[r] && pend1[r] && psrc1[r] == wb_preg[p]) begin
                        pend1[r] = 1'b0;
                        val1[r]  = wb_data[p];
                    end
                    if (wb_valid[p] && live[r] && pend2[r] && psrc2[r] == wb_preg[p]) begin
                        pend2[r] = 1'b0;
                        val2[r]  = wb_data[p];
                    end
                end
            end
            if (iss_req && !req_q && iss_ack) begin
                report("iss_req rose while iss_ack was high");
            end
            if (iss_req && req_q && pkt_q !== {iss_opcode, iss_robid, iss_pdst,
                                               iss_src1_val, iss_src2_val}) begin
                report("issue fields changed while iss_req was high");
            end
            if (iss_req && iss_ack && !ack_q) begin
                if (!live[iss_robid]) begin
                    report($sformatf("robid %0d issued without a pending dispatch", iss_robid));
                end else begin
                    if (iss_opcode !== opc[iss_robid] || iss_pdst !== pdst[iss_robid]) begin
                        report($sformatf("robid %0d opcode or pdst mismatch", iss_robid));
                    end
                    if (pend1[iss_robid] || pend2[iss_robid]) begin
                        report($sformatf("robid %0d issued before its writeback", iss_robid));
                    end else if (iss_src1_val !== val1[iss_robid] ||
                                 iss_src2_val !== val2[iss_robid]) begin
                        report($sformatf("robid %0d source value %h/%h, expected %h/%h",
                            iss_robid, iss_src1_val, iss_src2_val,
                            val1[iss_robid], val2[iss_robid]));
                    end
                    live[iss_robid] = 1'b0;
                end
                issued_count <= issued_count + 1;
            end
        end
        reset_q <= reset;
        req_q   <= iss_req;
        ack_q   <= iss_ack;
        pkt_q   <= {iss_opcode, iss_robid, iss_pdst, iss_src1_val, iss_src2_val};
    end

endmodule

/* testbench/rs_tb.sv */
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_tb;

    localparam int NUM_ROWS  = 12;
    localparam int RST_CYC   = 16;
    localparam int MAX_CYC   = NUM_ROWS * 40 + RST_CYC;
    localparam int STALL_CYC = 20;

    logic               clk = 1'b0;
    logic               reset = 1'b1;
    logic               disp_req = 1'b0;
    instr_pkg::t_opcode disp_opcode = '0;
    instr_pkg::t_robid  disp_robid = '0;
    instr_pkg::t_preg   disp_pdst = '0;
    instr_pkg::t_preg   disp_psrc1 = '0;
    instr_pkg::t_preg   disp_psrc2 = '0;
    logic               disp_src1_pend = 1'b0;
    logic               disp_src2_pend = 1'b0;
    instr_pkg::t_xdata  disp_src1_val = '0;
    instr_pkg::t_xdata  disp_src2_val = '0;
    logic               disp_ack;
    logic               wb_valid [`RS_NUM_WB-1:0];
    instr_pkg::t_preg   wb_preg  [`RS_NUM_WB-1:0];
    instr_pkg::t_xdata  wb_data  [`RS_NUM_WB-1:0];
    logic               iss_req;
    instr_pkg::t_opcode iss_opcode;
    instr_pkg::t_robid  iss_robid;
    instr_pkg::t_preg   iss_pdst;
    instr_pkg::t_xdata  iss_src1_val;
    instr_pkg::t_xdata  iss_src2_val;
    logic               iss_ack = 1'b0;

    int     chk_errors;
    int     issued_count;
    int     tb_errors = 0;
    int     disp_count = 0;
    int     cycles = 0;
    int     ack_wait = 0;
    logic   hold = 1'b0;
    integer seed = 32'h196f_011c;

    // Mode 0 plain, 1 wait for an empty station, 2 also start hold-off, 3 full-station stall
    instr_pkg::t_opcode t_opc [NUM_ROWS];
    instr_pkg::t_preg   t_pdst [NUM_ROWS];
    instr_pkg::t_preg   t_ps1 [NUM_ROWS];
    instr_pkg::t_preg   t_ps2 [NUM_ROWS];
    logic               t_pn1 [NUM_ROWS];
    logic               t_pn2 [NUM_ROWS];
    instr_pkg::t_xdata  t_v1 [NUM_ROWS];
    instr_pkg::t_xdata  t_v2 [NUM_ROWS];
    int                 t_port1 [NUM_ROWS];
    int                 t_dly1 [NUM_ROWS];
    int                 t_port2 [NUM_ROWS];
    int                 t_dly2 [NUM_ROWS];
    int                 t_mode [NUM_ROWS];
    int                 n_rows = 0;

    always #20 clk = ~clk;

    rs_top rs_top_i (.*);

    rs_checker rs_checker_i (.*, .err_count(chk_errors), .issued_count(issued_count));

    task add_row(input int opc, input int pdst, input int ps1, input int pn1, input int d1v,
                 input int port1, input int dly1, input int ps2, input int pn2,
                 input int d2v, input int port2, input int dly2, input int mode);
        t_opc[n_rows]   = opc;
        t_pdst[n_rows]  = pdst;
        t_ps1[n_rows]   = ps1;
        t_pn1[n_rows]   = pn1;
        t_v1[n_rows]    = d1v;
        t_port1[n_rows] = port1;
        t_dly1[n_rows]  = dly1;
        t_ps2[n_rows]   = ps2;
        t_pn2[n_rows]   = pn2;
        t_v2[n_rows]    = d2v;
        t_port2[n_rows] = port2;
        t_dly2[n_rows]  = dly2;
        t_mode[n_rows]  = mode;
        n_rows = n_rows + 1;
    endtask

    task drive_wb(input int port, input instr_pkg::t_preg preg, input instr_pkg::t_xdata data);
        wb_valid[port] <= 1'b1;
        wb_preg[port]  <= preg;
        wb_data[port]  <= data;
    endtask

    task wait_empty;
        while (disp_count != issued_count) begin
            @(posedge clk);
        end
    endtask

    // Four-phase dispatch of one row plus the writebacks that wake its sources
    task dispatch_row(input int r);
        int                t;
        int                since;
        int                base_issued;
        int                max_dly;
        logic              acked;
        instr_pkg::t_xdata wbd1;
        instr_pkg::t_xdata wbd2;
        t = 0;
        since = 0;
        acked = 1'b0;
        base_issued = 0;
        max_dly = (t_dly1[r] > t_dly2[r]) ? t_dly1[r] : t_dly2[r];
        wbd1 = $random(seed);
        wbd2 = $random(seed);
        if (t_mode[r] == 1 || t_mode[r] == 2) begin
            wait_empty();
        end
        if (t_mode[r] == 2) begin
            hold <= 1'b1;
        end
        disp_req       <= 1'b1;
        disp_opcode    <= t_opc[r];
        disp_robid     <= r;
        disp_pdst      <= t_pdst[r];
        disp_psrc1     <= t_ps1[r];
        disp_psrc2     <= t_ps2[r];
        disp_src1_pend <= t_pn1[r];
        disp_src2_pend <= t_pn2[r];
        disp_src1_val  <= t_v1[r];
        disp_src2_val  <= t_v2[r];
        if (t_mode[r] == 3) begin
            repeat (STALL_CYC) begin
                @(posedge clk);
                if (disp_ack) begin
                    tb_errors = tb_errors + 1;
                    $display("Error at %0t ns: disp_ack while all entries are taken", $time);
                end
            end
            base_issued = issued_count;
            hold <= 1'b0;
        end
        while (!(acked && !disp_ack && since >= max_dly)) begin
            @(posedge clk);
            wb_valid[0] <= 1'b0;
            wb_valid[1] <= 1'b0;
            if (acked) begin
                since = since + 1;
            end else if (disp_ack) begin
                acked = 1'b1;
                since = 1;
                disp_count = disp_count + 1;
                disp_req <= 1'b0;
                if (t_mode[r] == 3 && issued_count == base_issued) begin
                    tb_errors = tb_errors + 1;
                    $display("Error at %0t ns: disp_ack before an issue freed an entry", $time);
                end
            end
            if (t_pn1[r] && ((t_dly1[r] == 0 && t == 0) || (acked && since == t_dly1[r]))) begin
                drive_wb(t_port1[r], t_ps1[r], wbd1);
            end
            if (t_pn2[r] && ((t_dly2[r] == 0 && t == 0) || (acked && since == t_dly2[r]))) begin
                drive_wb(t_port2[r], t_ps2[r], wbd2);
            end
            t = t + 1;
        end
        @(posedge clk);
        wb_valid[0] <= 1'b0;
        wb_valid[1] <= 1'b0;
    endtask

    // Issue consumer with a random hold before each acknowledge
    always @(posedge clk) begin
        if (reset) begin
            iss_ack <= 1'b0;
        end else if (iss_ack) begin
            if (!iss_req) begin
                iss_ack <= 1'b0;
            end
        end else if (iss_req && !hold) begin
            if (ack_wait == 0) begin
                iss_ack <= 1'b1;
            end else begin
                ack_wait <= ack_wait - 1;
            end
        end else if (!iss_req) begin
            ack_wait <= $random(seed) & 7;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYC) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYC);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        for (int p = 0; p < `RS_NUM_WB; p++) begin
            wb_valid[p] = 1'b0;
            wb_preg[p]  = '0;
            wb_data[p]  = '0;
        end
        //      opc pdst ps1 pn d1v        port dly ps2 pn d2v        port dly mode
        add_row(1,  10,  1,  0, 32'h1111,  0,   0,  2,  0, 32'h2222,  0,   0,  1);
        add_row(2,  11,  20, 1, 0,         0,   0,  3,  0, 32'h3333,  0,   0,  1);
        add_row(3,  12,  4,  0, 32'h4444,  0,   0,  21, 1, 0,         1,   0,  1);
        add_row(4,  13,  22, 1, 0,         0,   3,  23, 1, 0,         1,   3,  0);
        add_row(5,  14,  5,  0, 32'h5555,  0,   0,  6,  0, 32'h6666,  0,   0,  2);
        add_row(6,  15,  24, 1, 0,         1,   2,  7,  0, 32'h7777,  0,   0,  0);
        add_row(7,  16,  8,  0, 32'h8888,  0,   0,  25, 1, 0,         0,   5,  0);
        add_row(8,  17,  9,  0, 32'h9999,  0,   0,  12, 0, 32'haaaa,  0,   0,  0);
        add_row(9,  18,  26, 1, 0,         0,   1,  13, 0, 32'hbbbb,  0,   0,  3);
        add_row(10, 19,  27, 1, 0,         1,   4,  28, 1, 0,         0,   1,  0);
        add_row(11, 30,  29, 1, 0,         1,   0,  14, 0, 32'hcccc,  0,   0,  1);
        add_row(12, 31,  15, 0, 32'hdddd,  0,   0,  16, 0, 32'heeee,  0,   0,  0);
        repeat (RST_CYC) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        for (int r = 0; r < NUM_ROWS; r++) begin
            dispatch_row(r);
        end
        while (issued_count < NUM_ROWS) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("Errors: %0d total, %0d from checker, %0d from testbench",
                 chk_errors + tb_errors, chk_errors, tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* rs_subsys.f */
+incdir+include
hw/instr_pkg.sv
hw/rs_pkg.sv
hw/rs_reg_trk.sv
hw/rs_entry.sv
hw/rs_dispatch_in.sv
hw/rs_issue_select.sv
hw/rs_top.sv
testbench/rs_checker.sv
testbench/rs_tb.sv

/* Bender.yml */
package:
  name: rs_subsys

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/instr_pkg.sv
      - hw/rs_pkg.sv
      - hw/rs_reg_trk.sv
      - hw/rs_entry.sv
      - hw/rs_dispatch_in.sv
      - hw/rs_issue_select.sv
      - hw/rs_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/rs_checker.sv
      - testbench/rs_tb.sv
